/* list.f */
+incdir+hdl
hdl/mem_unit_pkg.sv
hdl/smem_split.sv
hdl/shared_mem.sv
hdl/mem_arb.sv
hdl/mem_perf_counters.sv
hdl/mem_perf_regs.sv
hdl/mem_unit.sv
test/tb_mem_unit.sv

/* Bender.yml */
package:
  name: mem_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_unit_pkg.sv
      - hdl/smem_split.sv
      - hdl/shared_mem.sv
      - hdl/mem_arb.sv
      - hdl/mem_perf_counters.sv
      - hdl/mem_perf_regs.sv
      - hdl/mem_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_mem_unit.sv

/* test/tb_mem_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_unit_config.svh"

module tb_mem_unit import mem_unit_pkg::*; ();

    localparam word_t MODEL_KEY = 32'hA5A5_A5A5;
    localparam int    TIMEOUT   = 200;

    // one row of the stimulus table, port 0 fetch, 1 data, 2 fetch and data together
    typedef struct packed {
        logic [1:0] port;
        logic       rw;
        logic       sm;
        addr_t      addr;
        byteen_t    byteen;
        word_t      data;
        core_tag_t  tag;
    } stim_t;

    logic       clk;
    logic       reset;
    fetch_req_t fetch_req;
    logic       fetch_req_valid;
    logic       fetch_req_ready;
    core_rsp_t  fetch_rsp;
    logic       fetch_rsp_valid;
    logic       fetch_rsp_ready;
    data_req_t  data_req;
    logic       data_req_valid;
    logic       data_req_ready;
    core_rsp_t  data_rsp;
    logic       data_rsp_valid;
    logic       data_rsp_ready;
    mem_req_t   mem_req;
    logic       mem_req_valid;
    logic       mem_req_ready;
    mem_rsp_t   mem_rsp;
    logic       mem_rsp_valid;
    logic       mem_rsp_ready;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    addr_t      wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_ack;

    stim_t      stim_q[$];
    word_t      smem_model [`SMEM_DEPTH];
    mem_req_t   xfer_q[$];
    mem_rsp_t   pend_rsp[$];
    int         pend_delay[$];
    logic [15:0] lfsr;
    logic       counting;
    perf_ctr_t  cnt_reads;
    perf_ctr_t  cnt_writes;
    perf_ctr_t  cnt_stalls;
    perf_ctr_t  cnt_latency;
    perf_ctr_t  outst;
    int         err_count;
    int         check_count;

    mem_unit u_dut (
        .clk             (clk),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_req        (data_req),
        .data_req_valid  (data_req_valid),
        .data_req_ready  (data_req_ready),
        .data_rsp        (data_rsp),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp_ready  (data_rsp_ready),
        .mem_req         (mem_req),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp         (mem_rsp),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_ready   (mem_rsp_ready),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    // what external memory holds at a byte address
    function automatic word_t model_word(input addr_t a);
        model_word = (a >> 2) ^ MODEL_KEY;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("checks: %0d, errors: %0d", check_count, err_count);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // finds the memory port transfer carrying the expected tag
    task automatic check_xfer(input mem_req_t exp);
        int found;
        found = -1;
        for (int i = 0; i < xfer_q.size(); i++) begin
            if (found < 0 && xfer_q[i].tag == exp.tag) begin
                found = i;
            end
        end
        check_count++;
        if (found < 0) begin
            err_count++;
            $display("error at %0t: no memory port transfer with tag %h", $time, exp.tag);
        end else begin
            if (xfer_q[found] !== exp) begin
                err_count++;
                $display("error at %0t: memory port request %h, expected %h",
                         $time, xfer_q[found], exp);
            end
            xfer_q.delete(found);
        end
    endtask

    // memory model, ready dithering and pin-level counting
    initial begin : memory_model
        logic     b0;
        logic     b1;
        logic     rd_fire;
        logic     rsp_fire;
        mem_rsp_t r;
        lfsr            = 16'd50;
        mem_req_ready   = 1'b0;
        mem_rsp         = '0;
        mem_rsp_valid   = 1'b0;
        fetch_rsp_ready = 1'b0;
        data_rsp_ready  = 1'b0;
        counting        = 1'b0;
        outst           = '0;
        cnt_reads       = '0;
        cnt_writes      = '0;
        cnt_stalls      = '0;
        cnt_latency     = '0;
        forever begin
            @(posedge clk);
            if (!reset) begin
                rd_fire  = mem_req_valid && mem_req_ready && !mem_req.rw;
                rsp_fire = mem_rsp_valid && mem_rsp_ready;
                if (counting) begin
                    if (rd_fire) begin
                        cnt_reads++;
                    end
                    if (mem_req_valid && mem_req_ready && mem_req.rw) begin
                        cnt_writes++;
                    end
                    if (mem_req_valid && !mem_req_ready) begin
                        cnt_stalls++;
                    end
                    cnt_latency = cnt_latency + outst;
                end
                outst = outst + rd_fire - rsp_fire;
                if (rsp_fire) begin
                    pend_rsp.delete(0);
                    pend_delay.delete(0);
                end
                if (mem_req_valid && mem_req_ready) begin
                    xfer_q.push_back(mem_req);
                    if (!mem_req.rw) begin
                        r.data = model_word(mem_req.addr);
                        r.tag  = mem_req.tag;
                        pend_rsp.push_back(r);
                        take_bit(b0);
                        take_bit(b1);
                        pend_delay.push_back({b1, b0});
                    end
                end
            end
            #1;
            take_bit(b0);
            mem_req_ready = b0;
            take_bit(b0);
            fetch_rsp_ready = b0;
            take_bit(b0);
            data_rsp_ready = b0;
            // responses in order, each after its own delay
            if (pend_rsp.size() > 0 && pend_delay[0] == 0) begin
                mem_rsp       = pend_rsp[0];
                mem_rsp_valid = 1'b1;
            end else begin
                mem_rsp_valid = 1'b0;
                if (pend_rsp.size() > 0) begin
                    pend_delay[0] = pend_delay[0] - 1;
                end
            end
        end
    end

    task automatic add_stim(input logic [1:0] port, input logic rw, input logic sm,
                            input addr_t addr, input byteen_t byteen, input word_t data,
                            input core_tag_t tag);
        stim_t s;
        s.port   = port;
        s.rw     = rw;
        s.sm     = sm;
        s.addr   = addr;
        s.byteen = byteen;
        s.data   = data;
        s.tag    = tag;
        stim_q.push_back(s);
    endtask

    task automatic run_fetch(input addr_t addr, input core_tag_t tag);
        core_rsp_t rsp;
        mem_req_t  exp;
        int        n;
        fetch_req.addr  = addr;
        fetch_req.tag   = tag;
        fetch_req_valid = 1'b1;
        n = 0;
        @(posedge clk);
        while (!fetch_req_ready) begin
            n++;
            if (n > TIMEOUT) abort_run("fetch request was never accepted");
            @(posedge clk);
        end
        #1;
        fetch_req_valid = 1'b0;
        n = 0;
        @(posedge clk);
        while (!(fetch_rsp_valid && fetch_rsp_ready)) begin
            n++;
            if (n > TIMEOUT) abort_run("fetch response never arrived");
            @(posedge clk);
        end
        rsp = fetch_rsp;
        #1;
        check_word("fetch response data", rsp.data, model_word(addr));
        check_word("fetch response tag", word_t'(rsp.tag), word_t'(tag));
        exp.rw     = 1'b0;
        exp.byteen = '0;
        exp.addr   = addr;
        exp.data   = '0;
        exp.tag    = {1'b0, tag};
        check_xfer(exp);
    endtask

    task automatic run_data(input stim_t s);
        core_rsp_t rsp;
        mem_req_t  exp;
        word_t     want;
        int        idx;
        int        n;
        data_req.rw     = s.rw;
        data_req.byteen = s.byteen;
        data_req.addr   = s.addr;
        data_req.data   = s.data;
        data_req.tag    = s.tag;
        data_req.sm     = s.sm;
        data_req_valid  = 1'b1;
        n = 0;
        @(posedge clk);
        while (!data_req_ready) begin
            n++;
            if (n > TIMEOUT) abort_run("data request was never accepted");
            @(posedge clk);
        end
        #1;
        data_req_valid = 1'b0;
        idx = (s.addr >> 2) % `SMEM_DEPTH;
        if (s.sm && s.rw) begin
            for (int i = 0; i < $bits(byteen_t); i++) begin
                if (s.byteen[i]) begin
                    smem_model[idx][i*8 +: 8] = s.data[i*8 +: 8];
                end
            end
        end
        if (!s.rw) begin
            n = 0;
            @(posedge clk);
            while (!(data_rsp_valid && data_rsp_ready)) begin
                n++;
                if (n > TIMEOUT) abort_run("data response never arrived");
                @(posedge clk);
            end
            rsp = data_rsp;
            #1;
            want = s.sm ? smem_model[idx] : model_word(s.addr);
            check_word("data response data", rsp.data, want);
            check_word("data response tag", word_t'(rsp.tag), word_t'(s.tag));
        end
        if (!s.sm) begin
            exp.rw     = s.rw;
            exp.byteen = s.byteen;
            exp.addr   = s.addr;
            exp.data   = s.data;
            exp.tag    = {1'b1, s.tag};
            check_xfer(exp);
        end
    endtask

    task automatic run_table();
        stim_t s;
        for (int i = 0; i < stim_q.size(); i++) begin
            s = stim_q[i];
            case (s.port)
                2'd0: run_fetch(s.addr, s.tag);
                2'd1: run_data(s);
                default: begin
                    fork
                        run_fetch(s.addr, s.tag);
                        run_data(s);
                    join
                end
            endcase
            check_count++;
            if (xfer_q.size() != 0) begin
                err_count++;
                $display("error at %0t: entry %0d left %0d unexpected memory port transfers",
                         $time, i, xfer_q.size());
                xfer_q.delete();
            end
        end
    endtask

    task automatic wait_mem_idle();
        int n;
        n = 0;
        @(posedge clk);
        #1;
        while (pend_rsp.size() != 0 || mem_req_valid) begin
            n++;
            if (n > TIMEOUT) abort_run("memory port did not go idle");
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wb_access(input logic we, input addr_t adr, input word_t wdat,
                             output word_t rdat);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        n = 0;
        @(posedge clk);
        while (!wb_ack) begin
            n++;
            if (n > TIMEOUT) abort_run("wishbone access was not acknowledged");
            @(posedge clk);
        end
        rdat = wb_dat_r;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input addr_t adr, input word_t wdat);
        word_t unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input addr_t adr, output word_t rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic check_counters(input perf_ctr_t er, input perf_ctr_t ew,
                                  input perf_ctr_t es, input perf_ctr_t el);
        word_t v;
        wb_read(`PERF_REG_READS, v);
        check_word("read counter", v, er);
        wb_read(`PERF_REG_WRITES, v);
        check_word("write counter", v, ew);
        wb_read(`PERF_REG_STALLS, v);
        check_word("stall counter", v, es);
        wb_read(`PERF_REG_LATENCY, v);
        check_word("latency counter", v, el);
    endtask

    initial begin : main
        word_t v;
        reset           = 1'b1;
        fetch_req       = '0;
        fetch_req_valid = 1'b0;
        data_req        = '0;
        data_req_valid  = 1'b0;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        err_count       = 0;
        check_count     = 0;
        for (int i = 0; i < `SMEM_DEPTH; i++) begin
            smem_model[i] = '0;
        end

        add_stim(2'd0, 1'b0, 1'b0, 32'h0000_1000, 4'h0, 32'h0000_0000, 4'h1);
        add_stim(2'd0, 1'b0, 1'b0, 32'h0000_2344, 4'h0, 32'h0000_0000, 4'h2);
        add_stim(2'd1, 1'b1, 1'b1, 32'h0000_0040, 4'hF, 32'h1122_3344, 4'h3);
        add_stim(2'd1, 1'b1, 1'b1, 32'h0000_0044, 4'hF, 32'h5566_7788, 4'h4);
        add_stim(2'd1, 1'b1, 1'b1, 32'h0000_0040, 4'h5, 32'hAABB_CCDD, 4'h5);
        add_stim(2'd1, 1'b0, 1'b1, 32'h0000_0040, 4'hF, 32'h0000_0000, 4'h6);
        add_stim(2'd1, 1'b0, 1'b1, 32'h0000_0044, 4'hF, 32'h0000_0000, 4'h7);
        add_stim(2'd1, 1'b1, 1'b0, 32'h8000_0010, 4'h3, 32'hDEAD_BEEF, 4'h8);
        add_stim(2'd1, 1'b0, 1'b0, 32'h8000_0020, 4'hF, 32'h0BAD_F00D, 4'h9);
        add_stim(2'd2, 1'b0, 1'b0, 32'h0000_3000, 4'hF, 32'h0000_0000, 4'hA);
        add_stim(2'd2, 1'b0, 1'b0, 32'h0000_3100, 4'h0, 32'h0000_0000, 4'hB);
        add_stim(2'd1, 1'b0, 1'b0, 32'h1234_5678, 4'hF, 32'h0000_0000, 4'hC);
        add_stim(2'd1, 1'b1, 1'b1, 32'h0000_03FC, 4'hF, 32'hCAFE_F00D, 4'hD);
        add_stim(2'd1, 1'b0, 1'b1, 32'h0000_03FC, 4'hF, 32'h0000_0000, 4'hE);
        // aliases onto word 16 of the scratchpad
        add_stim(2'd1, 1'b0, 1'b1, 32'h0000_0440, 4'hF, 32'h0000_0000, 4'hF);

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        check_word("mem_req_valid after reset", word_t'(mem_req_valid), '0);
        check_word("fetch_rsp_valid after reset", word_t'(fetch_rsp_valid), '0);
        check_word("data_rsp_valid after reset", word_t'(data_rsp_valid), '0);
        check_word("wb_ack after reset", word_t'(wb_ack), '0);
        #1;

        // clear and enable, then count at the pins alongside
        wb_write(`PERF_REG_CTRL, 32'h3);
        cnt_reads   = '0;
        cnt_writes  = '0;
        cnt_stalls  = '0;
        cnt_latency = '0;
        counting    = 1'b1;
        run_table();
        wait_mem_idle();
        counting = 1'b0;
        check_counters(cnt_reads, cnt_writes, cnt_stalls, cnt_latency);

        // disabled counters hold their values
        wb_write(`PERF_REG_CTRL, 32'h0);
        run_table();
        wait_mem_idle();
        check_counters(cnt_reads, cnt_writes, cnt_stalls, cnt_latency);

        // read right after a nonzero latency value
        wb_read(32'h0000_0020, v);
        check_word("unknown offset", v, 32'h0);
        wb_read(`PERF_REG_CTRL, v);
        check_word("control register", v, 32'h0);

        wb_write(`PERF_REG_CTRL, 32'h2);
        check_counters('0, '0, '0, '0);

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/mem_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_unit import mem_unit_pkg::*; (
    input  wire             clk,
    input  wire             reset,

    // instruction fetch port
    input  wire fetch_req_t fetch_req,
    input  wire             fetch_req_valid,
    output logic            fetch_req_ready,
    output core_rsp_t       fetch_rsp,
    output logic            fetch_rsp_valid,
    input  wire             fetch_rsp_ready,

    // data port
    input  wire data_req_t  data_req,
    input  wire             data_req_valid,
    output logic            data_req_ready,
    output core_rsp_t       data_rsp,
    output logic            data_rsp_valid,
    input  wire             data_rsp_ready,

    // external memory
    output mem_req_t        mem_req,
    output logic            mem_req_valid,
    input  wire             mem_req_ready,
    input  wire mem_rsp_t   mem_rsp,
    input  wire             mem_rsp_valid,
    output logic            mem_rsp_ready,

    // counter registers
    input  wire             wb_cyc,
    input  wire             wb_stb,
    input  wire             wb_we,
    input  wire addr_t      wb_adr,
    input  wire word_t      wb_dat_w,
    output word_t           wb_dat_r,
    output logic            wb_ack
);

    data_req_t  smem_req;
    logic       smem_req_valid;
    logic       smem_req_ready;
    core_rsp_t  smem_rsp;
    logic       smem_rsp_valid;
    logic       smem_rsp_ready;

    data_req_t  ext_req;
    logic       ext_req_valid;
    logic       ext_req_ready;
    core_rsp_t  ext_rsp;
    logic       ext_rsp_valid;
    logic       ext_rsp_ready;

    perf_ctrl_t perf_ctrl;
    perf_ctr_t  perf_reads;
    perf_ctr_t  perf_writes;
    perf_ctr_t  perf_stalls;
    perf_ctr_t  perf_latency;

    smem_split u_smem_split (
        .data_req       (data_req),
        .data_req_valid (data_req_valid),
        .data_req_ready (data_req_ready),
        .data_rsp       (data_rsp),
        .data_rsp_valid (data_rsp_valid),
        .data_rsp_ready (data_rsp_ready),
        .smem_req       (smem_req),
        .smem_req_valid (smem_req_valid),
        .smem_req_ready (smem_req_ready),
        .smem_rsp       (smem_rsp),
        .smem_rsp_valid (smem_rsp_valid),
        .smem_rsp_ready (smem_rsp_ready),
        .ext_req        (ext_req),
        .ext_req_valid  (ext_req_valid),
        .ext_req_ready  (ext_req_ready),
        .ext_rsp        (ext_rsp),
        .ext_rsp_valid  (ext_rsp_valid),
        .ext_rsp_ready  (ext_rsp_ready)
    );

    shared_mem u_shared_mem (
        .clk       (clk),
        .reset     (reset),
        .req       (smem_req),
        .req_valid (smem_req_valid),
        .req_ready (smem_req_ready),
        .rsp       (smem_rsp),
        .rsp_valid (smem_rsp_valid),
        .rsp_ready (smem_rsp_ready)
    );

    // fetch and external data share the memory port
    mem_arb u_mem_arb (
        .clk             (clk),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_req        (ext_req),
        .data_req_valid  (ext_req_valid),
        .data_req_ready  (ext_req_ready),
        .data_rsp        (ext_rsp),
        .data_rsp_valid  (ext_rsp_valid),
        .data_rsp_ready  (ext_rsp_ready),
        .mem_req         (mem_req),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp         (mem_rsp),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    mem_perf_counters u_perf_counters (
        .clk           (clk),
        .reset         (reset),
        .perf_ctrl     (perf_ctrl),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_rw    (mem_req.rw),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .reads         (perf_reads),
        .writes        (perf_writes),
        .stalls        (perf_stalls),
        .latency       (perf_latency)
    );

    mem_perf_regs u_perf_regs (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .reads     (perf_reads),
        .writes    (perf_writes),
        .stalls    (perf_stalls),
        .latency   (perf_latency),
        .perf_ctrl (perf_ctrl)
    );

endmodule

`default_nettype wire

/* hdl/mem_perf_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_unit_config.svh"

module mem_perf_regs import mem_unit_pkg::*; (
    input  wire            clk,
    input  wire            reset,

    // wishbone classic slave
    input  wire            wb_cyc,
    input  wire            wb_stb,
    input  wire            wb_we,
    input  wire addr_t     wb_adr,
    input  wire word_t     wb_dat_w,
    output word_t          wb_dat_r,
    output logic           wb_ack,

    // counter values
    input  wire perf_ctr_t reads,
    input  wire perf_ctr_t writes,
    input  wire perf_ctr_t stalls,
    input  wire perf_ctr_t latency,

    output perf_ctrl_t     perf_ctrl
);

    logic  access;
    logic  ctrl_wr;
    word_t rd_mux;

    // single-cycle ack, low again for at least one cycle
    assign access  = wb_cyc && wb_stb && !wb_ack;
    assign ctrl_wr = access && wb_we && (wb_adr == `PERF_REG_CTRL);

    always_comb begin
        case (wb_adr)
            `PERF_REG_CTRL:    rd_mux = word_t'(perf_ctrl.enable);
            `PERF_REG_READS:   rd_mux = reads;
            `PERF_REG_WRITES:  rd_mux = writes;
            `PERF_REG_STALLS:  rd_mux = stalls;
            `PERF_REG_LATENCY: rd_mux = latency;
            default:           rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack           <= 1'b0;
            perf_ctrl.enable <= 1'b0;
            perf_ctrl.clear  <= 1'b0;
        end else begin
            wb_ack          <= access;
            // bit 1 gives a one-cycle pulse
            perf_ctrl.clear <= ctrl_wr && wb_dat_w[1];
            if (ctrl_wr) begin
                perf_ctrl.enable <= wb_dat_w[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_perf_counters.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_perf_counters import mem_unit_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire perf_ctrl_t perf_ctrl,

    // memory port handshakes
    input  wire             mem_req_valid,
    input  wire             mem_req_ready,
    input  wire             mem_req_rw,
    input  wire             mem_rsp_valid,
    input  wire             mem_rsp_ready,

    output perf_ctr_t       reads,
    output perf_ctr_t       writes,
    output perf_ctr_t       stalls,
    output perf_ctr_t       latency
);

    perf_ctr_t outstanding;
    logic      rd_fire;
    logic      wr_fire;
    logic      rsp_fire;

    assign rd_fire  = mem_req_valid && mem_req_ready && !mem_req_rw;
    assign wr_fire  = mem_req_valid && mem_req_ready && mem_req_rw;
    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset || perf_ctrl.clear) begin
            outstanding <= '0;
            reads       <= '0;
            writes      <= '0;
            stalls      <= '0;
            latency     <= '0;
        end else begin
            // reads in flight, tracked even when disabled
            if (rd_fire && !rsp_fire) begin
                outstanding <= outstanding + 1'b1;
            end else if (!rd_fire && rsp_fire && outstanding != '0) begin
                outstanding <= outstanding - 1'b1;
            end

            if (perf_ctrl.enable) begin
                if (rd_fire) begin
                    reads <= reads + 1'b1;
                end
                if (wr_fire) begin
                    writes <= writes + 1'b1;
                end
                if (mem_req_valid && !mem_req_ready) begin
                    stalls <= stalls + 1'b1;
                end
                // one unit per read per cycle in flight
                latency <= latency + outstanding;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_arb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_unit_config.svh"

module mem_arb import mem_unit_pkg::*; (
    input  wire             clk,
    input  wire             reset,

    // fetch source, read only
    input  wire fetch_req_t fetch_req,
    input  wire             fetch_req_valid,
    output logic            fetch_req_ready,
    output core_rsp_t       fetch_rsp,
    output logic            fetch_rsp_valid,
    input  wire             fetch_rsp_ready,

    // external data source
    input  wire data_req_t  data_req,
    input  wire             data_req_valid,
    output logic            data_req_ready,
    output core_rsp_t       data_rsp,
    output logic            data_rsp_valid,
    input  wire             data_rsp_ready,

    // memory port
    output mem_req_t        mem_req,
    output logic            mem_req_valid,
    input  wire             mem_req_ready,
    input  wire mem_rsp_t   mem_rsp,
    input  wire             mem_rsp_valid,
    output logic            mem_rsp_ready
);

    logic prio_data;
    logic grant_data;
    logic rsp_is_data;

    // data wins when alone or when it holds the priority
    assign grant_data = data_req_valid && (!fetch_req_valid || prio_data);

    assign mem_req_valid   = fetch_req_valid || data_req_valid;
    assign fetch_req_ready = mem_req_ready && !grant_data;
    assign data_req_ready  = mem_req_ready && grant_data;

    always_comb begin
        if (grant_data) begin
            mem_req.rw     = data_req.rw;
            mem_req.byteen = data_req.byteen;
            mem_req.addr   = data_req.addr;
            mem_req.data   = data_req.data;
            mem_req.tag    = {1'b1, data_req.tag};
        end else begin
            // fetch is a plain read
            mem_req.rw     = 1'b0;
            mem_req.byteen = '0;
            mem_req.addr   = fetch_req.addr;
            mem_req.data   = '0;
            mem_req.tag    = {1'b0, fetch_req.tag};
        end
    end

    // pointer moves past the source just served
    always_ff @(posedge clk) begin
        if (reset) begin
            prio_data <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            prio_data <= !grant_data;
        end
    end

    // top tag bit names the source
    assign rsp_is_data = mem_rsp.tag[`MEM_CORE_TAG_WIDTH];

    assign fetch_rsp_valid = mem_rsp_valid && !rsp_is_data;
    assign data_rsp_valid  = mem_rsp_valid && rsp_is_data;

    assign fetch_rsp.data = mem_rsp.data;
    assign fetch_rsp.tag  = mem_rsp.tag[`MEM_CORE_TAG_WIDTH-1:0];
    assign data_rsp.data  = mem_rsp.data;
    assign data_rsp.tag   = mem_rsp.tag[`MEM_CORE_TAG_WIDTH-1:0];

    assign mem_rsp_ready = rsp_is_data ? data_rsp_ready : fetch_rsp_ready;

endmodule

`default_nettype wire

/* hdl/shared_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_unit_config.svh"

module shared_mem import mem_unit_pkg::*; (
    input  wire            clk,
    input  wire            reset,

    input  wire data_req_t req,
    input  wire            req_valid,
    output logic           req_ready,

    output core_rsp_t      rsp,
    output logic           rsp_valid,
    input  wire            rsp_ready
);

    localparam int IDX_W  = $clog2(`SMEM_DEPTH);
    localparam int OFS_W  = $clog2($bits(byteen_t));
    localparam int NBYTES = $bits(byteen_t);

    word_t            mem [`SMEM_DEPTH];
    logic [IDX_W-1:0] idx;
    logic             req_fire;

    // word address modulo the depth
    assign idx = req.addr[OFS_W +: IDX_W];

    // room when the response slot is empty or draining this cycle
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    // byte-enabled writes
    always_ff @(posedge clk) begin
        if (req_fire && req.rw) begin
            for (int i = 0; i < NBYTES; i++) begin
                if (req.byteen[i]) begin
                    mem[idx][i*8 +: 8] <= req.data[i*8 +: 8];
                end
            end
        end
    end

    // one-entry response register, reads only
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (req_fire && !req.rw) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && !req.rw) begin
            rsp.data <= mem[idx];
            rsp.tag  <= req.tag;
        end
    end

endmodule

`default_nettype wire

/* hdl/smem_split.sv */
`timescale 1ns/100ps
`default_nettype none

module smem_split import mem_unit_pkg::*; (
    // core data port
    input  wire data_req_t data_req,
    input  wire            data_req_valid,
    output logic           data_req_ready,
    output core_rsp_t      data_rsp,
    output logic           data_rsp_valid,
    input  wire            data_rsp_ready,

    // towards the scratchpad
    output data_req_t      smem_req,
    output logic           smem_req_valid,
    input  wire            smem_req_ready,
    input  wire core_rsp_t smem_rsp,
    input  wire            smem_rsp_valid,
    output logic           smem_rsp_ready,

    // towards external memory
    output data_req_t      ext_req,
    output logic           ext_req_valid,
    input  wire            ext_req_ready,
    input  wire core_rsp_t ext_rsp,
    input  wire            ext_rsp_valid,
    output logic           ext_rsp_ready
);

    // same payload on both sides, only one valid is raised
    assign smem_req = data_req;
    assign ext_req  = data_req;

    assign smem_req_valid = data_req_valid && data_req.sm;
    assign ext_req_valid  = data_req_valid && !data_req.sm;

    // ready from whichever side the sm flag picks
    assign data_req_ready = data_req.sm ? smem_req_ready : ext_req_ready;

    // scratchpad response has fixed priority
    assign data_rsp_valid = smem_rsp_valid || ext_rsp_valid;
    assign data_rsp       = smem_rsp_valid ? smem_rsp : ext_rsp;

    assign smem_rsp_ready = data_rsp_ready;
    // external side stalls while the scratchpad is answering
    assign ext_rsp_ready  = data_rsp_ready && !smem_rsp_valid;

endmodule

`default_nettype wire

/* hdl/mem_unit_pkg.sv */
`default_nettype none

`include "mem_unit_config.svh"

package mem_unit_pkg;

    typedef logic [`MEM_ADDR_WIDTH-1:0]       addr_t;
    typedef logic [`MEM_DATA_WIDTH-1:0]       word_t;
    typedef logic [`MEM_DATA_WIDTH/8-1:0]     byteen_t;
    typedef logic [`MEM_CORE_TAG_WIDTH-1:0]   core_tag_t;
    // core tag with the source bit on top
    typedef logic [`MEM_CORE_TAG_WIDTH:0]     mem_tag_t;
    typedef logic [`PERF_CTR_WIDTH-1:0]       perf_ctr_t;

    typedef struct packed {
        addr_t     addr;
        core_tag_t tag;
    } fetch_req_t;

    typedef struct packed {
        logic      rw;
        byteen_t   byteen;
        addr_t     addr;
        word_t     data;
        core_tag_t tag;
        logic      sm;
    } data_req_t;

    typedef struct packed {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

    typedef struct packed {
        logic     rw;
        byteen_t  byteen;
        addr_t    addr;
        word_t    data;
        mem_tag_t tag;
    } mem_req_t;

    typedef struct packed {
        word_t    data;
        mem_tag_t tag;
    } mem_rsp_t;

    typedef struct packed {
        logic enable;
        logic clear;
    } perf_ctrl_t;

endpackage

`default_nettype wire

/* hdl/mem_unit_config.svh */
`ifndef MEM_UNIT_CONFIG_SVH
`define MEM_UNIT_CONFIG_SVH

// bus widths
`define MEM_ADDR_WIDTH      32
`define MEM_DATA_WIDTH      32
`define MEM_CORE_TAG_WIDTH  4

// scratchpad size in words
`define SMEM_DEPTH          256

// performance counters
`define PERF_CTR_WIDTH      32

// register byte offsets on the wishbone side
`define PERF_REG_CTRL       32'h00
`define PERF_REG_READS      32'h04
`define PERF_REG_WRITES     32'h08
`define PERF_REG_STALLS     32'h0C
`define PERF_REG_LATENCY    32'h10

`endif
